// File: decode_checker.sv
`timescale 1ns/1ns

module decode_checker (
    input logic                 clk,
    input logic                 rst,
    input decode_pkg::decoded_t out
);

    // Pipeline register stays clear through reset
    reset_clears_out: assert property (@(posedge clk) !rst |-> out == '0)
        else $error("Decode output not cleared while in reset");

    load_store_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(out.ctrl.load && out.ctrl.store))
        else $error("Load and store flags set together");

    // Stores and branches never write a register
    rd_en_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(out.ctrl.rd_en && (out.ctrl.store || out.ctrl.branch)))
        else $error("Register write enabled on a store or branch");

endmodule

bind decode_stage decode_checker i_checker (
    .clk (clk),
    .rst (rst),
    .out (out)
);

// File: decode_pkg.sv
package decode_pkg;

    localparam int WORD_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int IMM_WIDTH      = 16;
    localparam int REG_COUNT      = 32;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;

    // Opcodes of the kept instruction groups
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'b1_0000,
        ALU_ADDU = 5'b1_0001,
        ALU_SUB  = 5'b1_0010,
        ALU_SUBU = 5'b1_0011,
        ALU_AND  = 5'b1_0100,
        ALU_OR   = 5'b1_0101,
        ALU_XOR  = 5'b1_0110,
        ALU_NOR  = 5'b1_0111,
        ALU_SLT  = 5'b1_1010,
        ALU_SLTU = 5'b1_1011,
        // Only lui uses the shifter now
        ALU_SLL  = 5'b0_0100
    } alu_mode_e;

    typedef enum logic [2:0] {
        BR_BLTZ = 3'b000,
        BR_BGEZ = 3'b001,
        BR_BEQ  = 3'b100,
        BR_BNE  = 3'b101,
        BR_BLEZ = 3'b110,
        BR_BGTZ = 3'b111
    } branch_mode_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b11
    } mem_size_e;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]           opcode;
        reg_addr_t            rs;
        reg_addr_t            rt;
        logic [IMM_WIDTH-1:0] imm;
    } instr_i_t;

    // Same word, register or immediate layout
    typedef union packed {
        instr_r_t rtype;
        instr_i_t itype;
    } instr_u;

    typedef struct packed {
        logic                 rs_en;
        reg_addr_t            rs_addr;
        logic                 rt_en;
        reg_addr_t            rt_addr;
        logic                 rd_en;
        reg_addr_t            rd_addr;
        logic                 imm_en;
        logic [IMM_WIDTH-1:0] imm;
        logic                 alu_en;
        alu_mode_e            alu_mode;
        logic                 branch;
        branch_mode_e         branch_mode;
        logic                 lui;
        logic                 load;
        logic                 load_signed;
        mem_size_e            mem_size;
        logic                 store;
    } decode_ctrl_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        word_t        pc;
        decode_ctrl_t ctrl;
        word_t        rs_data;
        word_t        rt_data;
    } decoded_t;

endpackage

// File: decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  decode_pkg::instr_u    instr,
    input  decode_pkg::word_t     pc,
    input  decode_pkg::wb_t       wb,
    output decode_pkg::decoded_t  out
);

    decode_pkg::decode_ctrl_t ctrl;
    decode_pkg::word_t        rs_data;
    decode_pkg::word_t        rt_data;

    instr_parser i_parser (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // Read addresses come straight from the parser in the same cycle
    reg_file i_regs (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (ctrl.rs_addr),
        .rt_addr (ctrl.rt_addr),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // Pipeline register toward execute
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out <= '0;
        end else begin
            out.pc      <= pc;
            out.ctrl    <= ctrl;
            out.rs_data <= rs_data;
            out.rt_data <= rt_data;
        end
    end

endmodule

// File: flist.f
decode_pkg.sv
instr_parser.sv
reg_file.sv
decode_stage.sv
decode_checker.sv
tb_decode_stage.sv

// File: instr_parser.sv
`timescale 1ns/1ns

module instr_parser (
    input  decode_pkg::instr_u       instr,
    output decode_pkg::decode_ctrl_t ctrl
);

    always_comb begin
        ctrl = '0;

        case (instr.rtype.opcode)
            decode_pkg::OP_SPECIAL: begin
                // funct 10_0xxx is arithmetic and logic, 10_101x is slt and sltu
                if (instr.rtype.shamt == '0 && instr.rtype.funct[5:4] == 2'b10 &&
                        (!instr.rtype.funct[3] || instr.rtype.funct[3:1] == 3'b101)) begin
                    ctrl.rs_en    = 1'b1;
                    ctrl.rs_addr  = instr.rtype.rs;
                    ctrl.rt_en    = 1'b1;
                    ctrl.rt_addr  = instr.rtype.rt;
                    ctrl.rd_en    = 1'b1;
                    ctrl.rd_addr  = instr.rtype.rd;
                    ctrl.alu_en   = 1'b1;
                    ctrl.alu_mode = decode_pkg::alu_mode_e'({instr.rtype.funct[5],
                                                             instr.rtype.funct[3:0]});
                end
            end

            decode_pkg::OP_REGIMM: begin
                // Only bltz and bgez; the linking forms fall through as no-ops
                if (instr.itype.rt[4:1] == 4'b0000) begin
                    ctrl.rs_en       = 1'b1;
                    ctrl.rs_addr     = instr.itype.rs;
                    ctrl.rt_en       = 1'b1;
                    ctrl.rt_addr     = '0;
                    ctrl.imm_en      = 1'b1;
                    ctrl.imm         = instr.itype.imm;
                    ctrl.branch      = 1'b1;
                    ctrl.branch_mode = decode_pkg::branch_mode_e'(instr.itype.rt[2:0]);
                end
            end

            decode_pkg::OP_BEQ, decode_pkg::OP_BNE,
            decode_pkg::OP_BLEZ, decode_pkg::OP_BGTZ: begin
                // blez and bgtz compare against zero, so rt must be register 0
                if (!instr.itype.opcode[1] || instr.itype.rt == '0) begin
                    ctrl.rs_en       = 1'b1;
                    ctrl.rs_addr     = instr.itype.rs;
                    ctrl.rt_en       = 1'b1;
                    ctrl.rt_addr     = instr.itype.rt;
                    ctrl.imm_en      = 1'b1;
                    ctrl.imm         = instr.itype.imm;
                    ctrl.branch      = 1'b1;
                    ctrl.branch_mode = decode_pkg::branch_mode_e'(instr.itype.opcode[2:0]);
                end
            end

            decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_ANDI,
            decode_pkg::OP_ORI, decode_pkg::OP_XORI: begin
                ctrl.rs_en    = 1'b1;
                ctrl.rs_addr  = instr.itype.rs;
                ctrl.rd_en    = 1'b1;
                ctrl.rd_addr  = instr.itype.rt;
                ctrl.imm_en   = 1'b1;
                ctrl.imm      = instr.itype.imm;
                ctrl.alu_en   = 1'b1;
                ctrl.alu_mode = decode_pkg::alu_mode_e'({2'b10, instr.itype.opcode[2:0]});
            end

            decode_pkg::OP_SLTI, decode_pkg::OP_SLTIU: begin
                ctrl.rs_en    = 1'b1;
                ctrl.rs_addr  = instr.itype.rs;
                ctrl.rd_en    = 1'b1;
                ctrl.rd_addr  = instr.itype.rt;
                ctrl.imm_en   = 1'b1;
                ctrl.imm      = instr.itype.imm;
                ctrl.alu_en   = 1'b1;
                ctrl.alu_mode = decode_pkg::alu_mode_e'({1'b1, instr.itype.opcode[3:0]});
            end

            decode_pkg::OP_LUI: begin
                if (instr.itype.rs == '0) begin
                    ctrl.rd_en    = 1'b1;
                    ctrl.rd_addr  = instr.itype.rt;
                    ctrl.imm_en   = 1'b1;
                    ctrl.imm      = instr.itype.imm;
                    ctrl.alu_en   = 1'b1;
                    ctrl.alu_mode = decode_pkg::ALU_SLL;
                    ctrl.lui      = 1'b1;
                end
            end

            decode_pkg::OP_LB, decode_pkg::OP_LH, decode_pkg::OP_LW,
            decode_pkg::OP_LBU, decode_pkg::OP_LHU: begin
                ctrl.rs_en       = 1'b1;
                ctrl.rs_addr     = instr.itype.rs;
                ctrl.rd_en       = 1'b1;
                ctrl.rd_addr     = instr.itype.rt;
                ctrl.imm_en      = 1'b1;
                ctrl.imm         = instr.itype.imm;
                ctrl.load        = 1'b1;
                // lbu and lhu have opcode bit 2 set
                ctrl.load_signed = ~instr.itype.opcode[2];
                ctrl.mem_size    = decode_pkg::mem_size_e'(instr.itype.opcode[1:0]);
            end

            decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW: begin
                ctrl.rs_en    = 1'b1;
                ctrl.rs_addr  = instr.itype.rs;
                ctrl.rt_en    = 1'b1;
                ctrl.rt_addr  = instr.itype.rt;
                ctrl.imm_en   = 1'b1;
                ctrl.imm      = instr.itype.imm;
                ctrl.store    = 1'b1;
                ctrl.mem_size = decode_pkg::mem_size_e'(instr.itype.opcode[1:0]);
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  decode_pkg::reg_addr_t rs_addr,
    input  decode_pkg::reg_addr_t rt_addr,
    input  decode_pkg::wb_t       wb,
    output decode_pkg::word_t     rs_data,
    output decode_pkg::word_t     rt_data
);

    // Register 0 is hard-wired, so storage starts at 1
    decode_pkg::word_t regs [1:decode_pkg::REG_COUNT-1];

    function automatic decode_pkg::word_t read_port(decode_pkg::reg_addr_t addr);
        decode_pkg::word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wb.en && wb.addr == addr) begin
            // Write-back in the same cycle wins over the stored word
            data = wb.data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int k = 1; k < decode_pkg::REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
verilator --binary --timing --assert --top-module tb_decode_stage -f flist.f \
    -o tb_decode_stage || { echo "Build failed"; exit 1; }
./obj_dir/tb_decode_stage > sim.log 2>&1 || { cat sim.log; echo "Simulation stopped early"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; } || exit 0

// File: tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage;

    localparam int TIMEOUT_CYCLES = 400;

    logic                 clk;
    logic                 rst;
    decode_pkg::instr_u   instr;
    decode_pkg::word_t    pc;
    decode_pkg::wb_t      wb;
    decode_pkg::decoded_t out;

    logic [15:0]       lfsr;
    decode_pkg::word_t model [0:31];
    int                errors;
    int                pass_count;
    int                fail_count;
    int                cycles;

    decode_stage i_dut (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .pc    (pc),
        .wb    (wb),
        .out   (out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not complete", cycles);
        $display("TEST FAIL");
        $finish;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic decode_pkg::word_t next_bits(input int count);
        logic              fb;
        decode_pkg::word_t w;
        w = '0;
        repeat (count) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            w = {w[30:0], fb};
        end
        return w;
    endfunction

    // Enable bits are rs rt rd imm
    function automatic decode_pkg::decode_ctrl_t ctrl_fields(input logic [3:0] en,
            input decode_pkg::reg_addr_t rs, rt, rd, input logic [15:0] imm);
        decode_pkg::decode_ctrl_t c;
        c = '0;
        c.rs_en = en[3];
        c.rs_addr = rs;
        c.rt_en = en[2];
        c.rt_addr = rt;
        c.rd_en = en[1];
        c.rd_addr = rd;
        c.imm_en = en[0];
        c.imm = imm;
        return c;
    endfunction

    task automatic apply_cycle(input logic [31:0] word, input decode_pkg::word_t addr,
            input decode_pkg::wb_t w);
        instr = word;
        pc = addr;
        wb = w;
        @(negedge clk);
    endtask

    task automatic word_check(input string name, input decode_pkg::word_t expected,
            input decode_pkg::word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic ctrl_check(input decode_pkg::decode_ctrl_t expected);
        if (out.ctrl !== expected) begin
            $display("MISMATCH ctrl expected %h actual %h", expected, out.ctrl);
            errors++;
        end
    endtask

    task automatic report_result(input string name);
        if (errors == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    task automatic reset_test();
        repeat (16) @(negedge clk);
        rst = 1'b1;
        if (out !== '0) begin
            $display("MISMATCH out expected 0 actual %h", out);
            errors++;
        end
        // addu r3, r5, r9 on cleared registers
        apply_cycle({6'h00, 5'd5, 5'd9, 5'd3, 5'd0, 6'h21}, 32'h40, '0);
        word_check("rs_data", '0, out.rs_data);
        word_check("rt_data", '0, out.rt_data);
        word_check("pc", 32'h40, out.pc);
        report_result("reset");
    endtask

    task automatic regfile_test();
        decode_pkg::word_t d;
        model[0] = '0;
        for (int k = 1; k < 32; k++) begin
            d = next_bits(32);
            model[k] = d;
            apply_cycle('0, 32'(4 * k), {1'b1, 5'(k), d});
        end
        apply_cycle('0, 32'h80, {1'b1, 5'd0, 32'h5a5a_a5a5});
        for (int k = 0; k < 32; k++) begin
            apply_cycle({6'h00, 5'(k), 5'(31 - k), 5'd1, 5'd0, 6'h20}, 32'(4 * k), '0);
            word_check("rs_data", model[k], out.rs_data);
            word_check("rt_data", model[31 - k], out.rt_data);
        end
        report_result("write and read");
    endtask

    task automatic forward_test();
        int targets [3];
        decode_pkg::word_t d;
        targets = '{4, 17, 31};
        foreach (targets[n]) begin
            d = next_bits(32);
            // Same-cycle write-back wins over the stored word
            apply_cycle({6'h00, 5'(targets[n]), 5'(targets[n]), 5'd2, 5'd0, 6'h20}, 32'h200,
                        {1'b1, 5'(targets[n]), d});
            word_check("rs_data", d, out.rs_data);
            word_check("rt_data", d, out.rt_data);
        end
        report_result("forwarding");
    endtask

    task automatic alu_test();
        logic [5:0] functs [10];
        logic [5:0] ops [7];
        decode_pkg::alu_mode_e funct_modes [10];
        decode_pkg::alu_mode_e op_modes [7];
        decode_pkg::decode_ctrl_t exp;
        decode_pkg::word_t imm;
        functs = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        funct_modes = '{decode_pkg::ALU_ADD, decode_pkg::ALU_ADDU, decode_pkg::ALU_SUB,
                        decode_pkg::ALU_SUBU, decode_pkg::ALU_AND, decode_pkg::ALU_OR,
                        decode_pkg::ALU_XOR, decode_pkg::ALU_NOR, decode_pkg::ALU_SLT,
                        decode_pkg::ALU_SLTU};
        ops = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e};
        op_modes = '{decode_pkg::ALU_ADD, decode_pkg::ALU_ADDU, decode_pkg::ALU_SLT,
                     decode_pkg::ALU_SLTU, decode_pkg::ALU_AND, decode_pkg::ALU_OR,
                     decode_pkg::ALU_XOR};
        foreach (functs[n]) begin
            exp = ctrl_fields(4'b1110, 5'(n + 1), 5'(n + 11), 5'(n + 21), '0);
            exp.alu_en = 1'b1;
            exp.alu_mode = funct_modes[n];
            apply_cycle({6'h00, 5'(n + 1), 5'(n + 11), 5'(n + 21), 5'd0, functs[n]},
                        32'h300, '0);
            ctrl_check(exp);
        end
        foreach (ops[n]) begin
            imm = next_bits(16);
            exp = ctrl_fields(4'b1011, 5'(n + 3), 5'd0, 5'(n + 12), imm[15:0]);
            exp.alu_en = 1'b1;
            exp.alu_mode = op_modes[n];
            apply_cycle({ops[n], 5'(n + 3), 5'(n + 12), imm[15:0]}, 32'h340, '0);
            ctrl_check(exp);
        end
        exp = ctrl_fields(4'b0011, 5'd0, 5'd0, 5'd7, 16'h1234);
        exp.alu_en = 1'b1;
        exp.alu_mode = decode_pkg::ALU_SLL;
        exp.lui = 1'b1;
        apply_cycle({6'h0f, 5'd0, 5'd7, 16'h1234}, 32'h380, '0);
        ctrl_check(exp);
        report_result("alu decoding");
    endtask

    task automatic mem_test();
        logic [5:0] ops [8];
        decode_pkg::mem_size_e sizes [8];
        logic signed_flags [8];
        decode_pkg::decode_ctrl_t exp;
        decode_pkg::word_t imm;
        ops = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
        sizes = '{decode_pkg::MEM_BYTE, decode_pkg::MEM_HALF, decode_pkg::MEM_WORD,
                  decode_pkg::MEM_BYTE, decode_pkg::MEM_HALF, decode_pkg::MEM_BYTE,
                  decode_pkg::MEM_HALF, decode_pkg::MEM_WORD};
        // lb lh lw sign-extend, lbu lhu do not
        signed_flags = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        foreach (ops[n]) begin
            imm = next_bits(16);
            if (!ops[n][3]) begin
                // Loads write the register named by rt
                exp = ctrl_fields(4'b1011, 5'(n + 1), 5'd0, 5'(n + 8), imm[15:0]);
                exp.load = 1'b1;
                exp.load_signed = signed_flags[n];
            end else begin
                exp = ctrl_fields(4'b1101, 5'(n + 1), 5'(n + 8), 5'd0, imm[15:0]);
                exp.store = 1'b1;
            end
            exp.mem_size = sizes[n];
            apply_cycle({ops[n], 5'(n + 1), 5'(n + 8), imm[15:0]}, 32'h400, '0);
            ctrl_check(exp);
        end
        report_result("loads and stores");
    endtask

    task automatic branch_test();
        logic [5:0] ops [6];
        decode_pkg::reg_addr_t rts [6];
        decode_pkg::branch_mode_e modes [6];
        logic [31:0] rejects [5];
        decode_pkg::decode_ctrl_t exp;
        ops = '{6'h04, 6'h05, 6'h06, 6'h07, 6'h01, 6'h01};
        rts = '{5'd4, 5'd6, 5'd0, 5'd0, 5'd0, 5'd1};
        modes = '{decode_pkg::BR_BEQ, decode_pkg::BR_BNE, decode_pkg::BR_BLEZ,
                  decode_pkg::BR_BGTZ, decode_pkg::BR_BLTZ, decode_pkg::BR_BGEZ};
        foreach (ops[n]) begin
            // Regimm reads register 0 in place of rt
            exp = ctrl_fields(4'b1101, 5'(n + 3), (ops[n] == 6'h01) ? 5'd0 : rts[n], 5'd0,
                              16'(n * 4));
            exp.branch = 1'b1;
            exp.branch_mode = modes[n];
            apply_cycle({ops[n], 5'(n + 3), rts[n], 16'(n * 4)}, 32'h500, '0);
            ctrl_check(exp);
        end
        // j, jal, jr, bltzal and sll
        rejects = '{{6'h02, 26'h40}, {6'h03, 26'h40}, {6'h00, 5'd4, 15'd0, 6'h08},
                    {6'h01, 5'd4, 5'd16, 16'h8}, {6'h00, 5'd0, 5'd3, 5'd3, 5'd4, 6'h00}};
        foreach (rejects[n]) begin
            apply_cycle(rejects[n], 32'(32'h600 + 4 * n), '0);
            ctrl_check('0);
            word_check("pc", 32'(32'h600 + 4 * n), out.pc);
        end
        report_result("branches and rejected words");
    endtask

    initial begin
        lfsr = 16'd15815;
        errors = 0;
        pass_count = 0;
        fail_count = 0;
        rst = 1'b1;
        instr = '0;
        pc = '0;
        wb = '0;
        #1 rst = 1'b0;
        reset_test();
        regfile_test();
        forward_test();
        alu_test();
        mem_test();
        branch_test();
        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
